// ==== all.f ====
+incdir+include
source/alu_pkg.sv
source/apb_pkg.sv
source/cla_block_4.sv
source/cla_adder.sv
source/sync_fifo.sv
source/apb_cmd_regs.sv
source/alu_pipe.sv
source/alu_subsystem_top.sv
testbench/tb_alu_subsystem.sv

// ==== testbench/tb_alu_subsystem.sv ====
`include "alu_consts.svh"

module tb_alu_subsystem;

    import alu_pkg::*;

    localparam int dw         = `ALU_DATA_W;
    localparam int max_cycles = 20000;
    localparam int fill_jobs  = `ALU_FIFO_DEPTH * 2 + 2;

    logic          clk;
    logic          arst_n;
    logic [7:0]    paddr;
    logic          psel;
    logic          penable;
    logic          pwrite;
    logic [dw-1:0] pwdata;
    logic [dw-1:0] prdata;
    logic          pslverr;

    // expected results in job order, observed results in read order
    alu_result_t exp_q[$];
    alu_result_t obs_q[$];
    int          errors;
    int          checks;
    int          tests;
    int          cycles;

    alu_subsystem_top i_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pslverr (pslverr)
    );

    always #5 clk = ~clk;

    // the whole sequence needs roughly 5000 cycles
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("run stopped after %0d cycles, the DUT stopped responding", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // add gives the carry out, subtract gives carry as "no borrow"
    function automatic alu_result_t ref_result(input logic [dw-1:0] a, input logic [dw-1:0] b,
                                               input logic sub);
        alu_result_t r;
        logic [dw:0] wide;
        if (sub) begin
            r.sum      = a - b;
            r.carry    = (a >= b);
            r.overflow = (a[dw-1] != b[dw-1]) && (r.sum[dw-1] != a[dw-1]);
        end else begin
            wide       = {1'b0, a} + {1'b0, b};
            r.sum      = wide[dw-1:0];
            r.carry    = wide[dw];
            r.overflow = (a[dw-1] == b[dw-1]) && (r.sum[dw-1] != a[dw-1]);
        end
        return r;
    endfunction

    task automatic compare(input string name, input logic [dw-1:0] got,
                           input logic [dw-1:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, want);
        end
    endtask

    // pairs each observed result with the oldest outstanding job
    always @(posedge clk) begin : compare_results
        alu_result_t seen;
        alu_result_t want;
        if (obs_q.size() > 0) begin
            seen = obs_q.pop_front();
            if (exp_q.size() == 0) begin
                errors++;
                $display("at %0t a result was read back while no job was outstanding", $time);
            end else begin
                want = exp_q.pop_front();
                compare("result sum", seen.sum, want.sum);
                compare("result carry", seen.carry, want.carry);
                compare("result overflow", seen.overflow, want.overflow);
            end
        end
    end

    // setup phase, then access phase, outputs sampled mid access phase
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [dw-1:0] wdata,
                            output logic [dw-1:0] rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [dw-1:0] wdata, output logic err);
        logic [dw-1:0] unused;
        apb_xfer(1'b1, addr, wdata, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [dw-1:0] rdata, output logic err);
        apb_xfer(1'b0, addr, '0, rdata, err);
    endtask

    task automatic push_job(input logic [dw-1:0] a, input logic [dw-1:0] b, input logic sub,
                            input logic accept);
        logic err;
        apb_write(`ALU_REG_OPA, a, err);
        compare("pslverr on OPA write", err, 1'b0);
        apb_write(`ALU_REG_OPB, b, err);
        compare("pslverr on OPB write", err, 1'b0);
        apb_write(`ALU_REG_CMD, {{(dw-1){1'b0}}, sub}, err);
        compare("pslverr on CMD write", err, !accept);
        if (accept && !err) begin
            exp_q.push_back(ref_result(a, b, sub));
        end
    endtask

    // poll STATUS until a result sits at the head of the result FIFO
    task automatic wait_head(output logic found);
        logic [dw-1:0] status;
        logic          err;
        int            tries;
        found = 1'b0;
        tries = 0;
        while (!found && tries < 64) begin
            apb_read(`ALU_REG_STATUS, status, err);
            found = status[1];
            tries++;
        end
    endtask

    task automatic read_result();
        logic          found;
        logic [dw-1:0] flags;
        logic [dw-1:0] sum;
        logic          err;
        alu_result_t   seen;
        wait_head(found);
        if (!found) begin
            errors++;
            $display("at %0t no result became ready for an accepted job", $time);
            if (exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
        end else begin
            apb_read(`ALU_REG_FLAGS, flags, err);
            compare("pslverr on FLAGS read", err, 1'b0);
            apb_read(`ALU_REG_RESULT, sum, err);
            compare("pslverr on RESULT read", err, 1'b0);
            seen.sum      = sum;
            seen.carry    = flags[0];
            seen.overflow = flags[1];
            obs_q.push_back(seen);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        while (obs_q.size() > 0) begin
            @(posedge clk);
        end
        @(negedge clk);
        tests++;
        $display("[%0t] test %0d %s: %s", $time, tests, name,
                 (errors == errors_before) ? "pass" : "fail");
    endtask

    initial begin
        logic [dw-1:0] rdata;
        logic [dw-1:0] a;
        logic [dw-1:0] b;
        logic          err;
        int            mark;
        clk     = 1'b0;
        arst_n  = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        errors  = 0;
        checks  = 0;
        tests   = 0;
        cycles  = 0;
        void'($urandom(83624));
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;

        mark = errors;
        push_job(32'h0000_0000, 32'h0000_0000, 1'b0, 1'b1);
        read_result();
        push_job(32'hFFFF_FFFF, 32'h0000_0001, 1'b0, 1'b1);
        read_result();
        push_job(32'h7FFF_FFFF, 32'h0000_0001, 1'b0, 1'b1);
        read_result();
        push_job(32'h0000_0000, 32'h0000_0001, 1'b1, 1'b1);
        read_result();
        push_job(32'h8000_0000, 32'h0000_0001, 1'b1, 1'b1);
        read_result();
        finish_test("directed edge cases", mark);

        mark = errors;
        for (int i = 0; i < 200; i++) begin
            push_job($urandom(), $urandom(), 1'($urandom()), 1'b1);
            read_result();
        end
        finish_test("random add and subtract", mark);

        // job FIFO, both pipeline stages and result FIFO all fill up
        mark = errors;
        for (int i = 0; i < fill_jobs; i++) begin
            push_job($urandom(), $urandom(), 1'($urandom()), 1'b1);
        end
        apb_read(`ALU_REG_STATUS, rdata, err);
        compare("STATUS job_ready while full", rdata[0], 1'b0);
        push_job($urandom(), $urandom(), 1'b0, 1'b0);
        for (int i = 0; i < fill_jobs; i++) begin
            read_result();
        end
        finish_test("buffering and back-pressure", mark);

        mark = errors;
        apb_read(`ALU_REG_STATUS, rdata, err);
        compare("STATUS head_valid while empty", rdata[1], 1'b0);
        apb_read(`ALU_REG_RESULT, rdata, err);
        compare("pslverr on empty RESULT read", err, 1'b1);
        compare("prdata on empty RESULT read", rdata, '0);
        finish_test("empty result read", mark);

        mark = errors;
        a = $urandom();
        b = $urandom();
        apb_write(`ALU_REG_OPA, a, err);
        apb_write(`ALU_REG_OPB, b, err);
        apb_read(`ALU_REG_OPA, rdata, err);
        compare("OPA read back", rdata, a);
        apb_read(`ALU_REG_OPB, rdata, err);
        compare("OPB read back", rdata, b);
        apb_read(8'h18, rdata, err);
        compare("pslverr on unmapped read", err, 1'b1);
        apb_write(8'hFC, a, err);
        compare("pslverr on unmapped write", err, 1'b1);
        finish_test("register read back and decode", mark);

        if (exp_q.size() > 0) begin
            errors++;
            $display("%0d accepted jobs never produced a result", exp_q.size());
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== source/alu_subsystem_top.sv ====
`include "alu_consts.svh"

module alu_subsystem_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  apb_pkg::apb_addr_t     paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`ALU_DATA_W-1:0] pwdata,
    output logic [`ALU_DATA_W-1:0] prdata,
    output logic                   pslverr
);

    import alu_pkg::*;

    // register block to job FIFO
    logic        job_valid;
    logic        job_ready;
    alu_job_t    job;
    // job FIFO to pipeline
    logic        pipe_valid;
    logic        pipe_ready;
    alu_job_t    pipe_job;
    // pipeline to result FIFO
    logic        res_valid;
    logic        res_ready;
    alu_result_t res;
    // result FIFO head back to the register block
    logic        head_valid;
    logic        head_pop;
    alu_result_t head;

    apb_cmd_regs i_apb_cmd_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pslverr    (pslverr),
        .job_valid  (job_valid),
        .job        (job),
        .job_ready  (job_ready),
        .head_valid (head_valid),
        .head       (head),
        .head_pop   (head_pop)
    );

    sync_fifo #(
        .payload_t (alu_job_t),
        .depth     (`ALU_FIFO_DEPTH)
    ) cmd_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (job_valid),
        .in_ready  (job_ready),
        .in_data   (job),
        .out_valid (pipe_valid),
        .out_ready (pipe_ready),
        .out_data  (pipe_job)
    );

    alu_pipe i_alu_pipe (
        .clk       (clk),
        .arst_n    (arst_n),
        .job_valid (pipe_valid),
        .job_ready (pipe_ready),
        .job       (pipe_job),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res       (res)
    );

    sync_fifo #(
        .payload_t (alu_result_t),
        .depth     (`ALU_FIFO_DEPTH)
    ) res_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (res_valid),
        .in_ready  (res_ready),
        .in_data   (res),
        .out_valid (head_valid),
        .out_ready (head_pop),
        .out_data  (head)
    );

endmodule

// ==== source/alu_pipe.sv ====
module alu_pipe (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 job_valid,
    output logic                 job_ready,
    input  alu_pkg::alu_job_t    job,
    output logic                 res_valid,
    input  logic                 res_ready,
    output alu_pkg::alu_result_t res
);

    import alu_pkg::*;

    logic        s1_valid;
    alu_job_t    s1_job;
    logic        s2_valid;
    alu_result_t s2_res;
    logic        s1_free;
    logic        s2_free;
    alu_result_t add_out;

    // a stage is free when empty or when its content moves on this cycle
    assign s2_free   = !s2_valid || res_ready;
    assign s1_free   = !s1_valid || s2_free;
    assign job_ready = s1_free;

    cla_adder i_cla_adder (
        .operand_a (s1_job.operand_a),
        .operand_b (s1_job.operand_b),
        .sub       (s1_job.op),
        .sum       (add_out.sum),
        .carry     (add_out.carry),
        .overflow  (add_out.overflow)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (s1_free) begin
                s1_valid <= job_valid;
            end
            if (s2_free) begin
                s2_valid <= s1_valid;
            end
        end
    end

    // payload follows the valid bits
    always_ff @(posedge clk) begin
        if (s1_free && job_valid) begin
            s1_job <= job;
        end
        if (s2_free && s1_valid) begin
            s2_res <= add_out;
        end
    end

    assign res_valid = s2_valid;
    assign res       = s2_res;

    // a job taken two cycles ago is offered now unless the output stalled in between
    a_latency: assert property (
        @(posedge clk) disable iff (!arst_n)
        $past(job_valid && job_ready, 2) && $past(s2_free) |-> res_valid
    );

endmodule

// ==== source/apb_cmd_regs.sv ====
`include "alu_consts.svh"

module apb_cmd_regs (
    input  logic                   clk,
    input  logic                   arst_n,
    input  apb_pkg::apb_addr_t     paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`ALU_DATA_W-1:0] pwdata,
    output logic [`ALU_DATA_W-1:0] prdata,
    output logic                   pslverr,
    output logic                   job_valid,
    output alu_pkg::alu_job_t      job,
    input  logic                   job_ready,
    input  logic                   head_valid,
    input  alu_pkg::alu_result_t   head,
    output logic                   head_pop
);

    import alu_pkg::*;
    import apb_pkg::*;

    apb_reg_e               reg_sel;
    logic                   access;
    logic                   wr_access;
    logic                   rd_access;
    logic                   cmd_wr;
    logic [`ALU_DATA_W-1:0] opa_q;
    logic [`ALU_DATA_W-1:0] opb_q;

    always_comb begin
        case (paddr)
            `ALU_REG_OPA:    reg_sel = REG_OPA;
            `ALU_REG_OPB:    reg_sel = REG_OPB;
            `ALU_REG_CMD:    reg_sel = REG_CMD;
            `ALU_REG_STATUS: reg_sel = REG_STATUS;
            `ALU_REG_RESULT: reg_sel = REG_RESULT;
            `ALU_REG_FLAGS:  reg_sel = REG_FLAGS;
            default:         reg_sel = REG_NONE;
        endcase
    end

    // every transfer completes in its access phase
    assign access    = psel && penable;
    assign wr_access = access && pwrite;
    assign rd_access = access && !pwrite;
    assign cmd_wr    = wr_access && (reg_sel == REG_CMD);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            opa_q <= '0;
            opb_q <= '0;
        end else if (wr_access) begin
            if (reg_sel == REG_OPA) begin
                opa_q <= pwdata;
            end
            if (reg_sel == REG_OPB) begin
                opb_q <= pwdata;
            end
        end
    end

    // a CMD write pushes only when the job FIFO has room
    assign job_valid     = cmd_wr && job_ready;
    assign job.operand_a = opa_q;
    assign job.operand_b = opb_q;
    assign job.op        = alu_op_e'(pwdata[0]);

    // reading RESULT consumes the head entry
    assign head_pop = rd_access && (reg_sel == REG_RESULT) && head_valid;

    always_comb begin
        prdata = '0;
        if (rd_access) begin
            case (reg_sel)
                REG_OPA:    prdata = opa_q;
                REG_OPB:    prdata = opb_q;
                REG_STATUS: prdata = {{(`ALU_DATA_W-2){1'b0}}, head_valid, job_ready};
                REG_RESULT: prdata = head_valid ? head.sum : '0;
                REG_FLAGS: begin
                    if (head_valid) begin
                        prdata = {{(`ALU_DATA_W-2){1'b0}}, head.overflow, head.carry};
                    end
                end
                default:    prdata = '0;
            endcase
        end
    end

    always_comb begin
        pslverr = 1'b0;
        if (access) begin
            case (reg_sel)
                REG_CMD:    pslverr = pwrite && !job_ready;
                // status and flags are read only
                REG_STATUS: pslverr = pwrite;
                REG_FLAGS:  pslverr = pwrite;
                REG_RESULT: pslverr = pwrite || !head_valid;
                REG_NONE:   pslverr = 1'b1;
                default:    pslverr = 1'b0;
            endcase
        end
    end

    // a CMD write either pushes a job or answers with pslverr, never both
    a_cmd_served: assert property (
        @(posedge clk) disable iff (!arst_n) cmd_wr |-> (job_valid != pslverr)
    );

    // master side protocol, access phase only after a setup phase
    a_penable_psel: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(penable) |-> psel
    );

endmodule

// ==== source/sync_fifo.sv ====
module sync_fifo #(
    parameter type         payload_t = logic [7:0],
    parameter int unsigned depth     = 4
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t   mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;

    assign full  = (count == cnt_w'(depth));
    assign empty = (count == '0);

    assign in_ready  = !full;
    assign out_valid = !empty;
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // a write into a full FIFO would overwrite the waiting head
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!arst_n) out_valid && !out_ready |=> $stable(out_data)
    );

    // reading an empty FIFO would move rd_ptr away from wr_ptr
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!arst_n) empty |-> (rd_ptr == wr_ptr)
    );

endmodule

// ==== source/cla_adder.sv ====
`include "alu_consts.svh"

module cla_adder (
    input  logic [`ALU_DATA_W-1:0] operand_a,
    input  logic [`ALU_DATA_W-1:0] operand_b,
    input  alu_pkg::alu_op_e       sub,
    output logic [`ALU_DATA_W-1:0] sum,
    output logic                   carry,
    output logic                   overflow
);

    import alu_pkg::*;

    localparam int n_blocks = `ALU_DATA_W / 4;

    logic              sub_bit;
    logic [n_blocks:0] chain;
    logic              b_sign;

    assign sub_bit  = (sub == ALU_SUB);
    // subtract enters as carry-in to finish the two's complement
    assign chain[0] = sub_bit;

    for (genvar i = 0; i < n_blocks; i++) begin : g_blk
        cla_block_4 i_blk (
            .operand_a (operand_a[4*i +: 4]),
            .operand_b (operand_b[4*i +: 4]),
            .cin       (chain[i]),
            .sub       (sub_bit),
            .sum       (sum[4*i +: 4]),
            .cout      (chain[i+1])
        );
    end

    // on subtract, carry out set means no borrow
    assign carry = chain[n_blocks];

    // sign of b as the adder actually saw it
    assign b_sign   = operand_b[`ALU_DATA_W-1] ^ sub_bit;
    assign overflow = (operand_a[`ALU_DATA_W-1] == b_sign) &&
                      (sum[`ALU_DATA_W-1] != b_sign);

endmodule

// ==== source/cla_block_4.sv ====
module cla_block_4 (
    input  logic [3:0] operand_a,
    input  logic [3:0] operand_b,
    input  logic       cin,
    input  logic       sub,
    output logic [3:0] sum,
    output logic       cout
);

    logic [3:0] b_eff;
    logic [3:0] g;
    logic [3:0] p;
    logic [4:0] c;

    // one's complement of b for subtract, the +1 comes in on cin
    assign b_eff = operand_b ^ {4{sub}};

    assign g = operand_a & b_eff;
    assign p = operand_a ^ b_eff;

    // every carry is a flat function of g, p and cin, no ripple
    assign c[0] = cin;
    assign c[1] = g[0] | (p[0] & cin);
    assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
    assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
                | (p[2] & p[1] & p[0] & cin);
    assign c[4] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
                | (p[3] & p[2] & p[1] & g[0])
                | (p[3] & p[2] & p[1] & p[0] & cin);

    assign sum  = p ^ c[3:0];
    assign cout = c[4];

endmodule

// ==== source/apb_pkg.sv ====
package apb_pkg;

    // byte address seen by the register block
    typedef logic [7:0] apb_addr_t;

    // decoded register select
    typedef enum logic [2:0] {
        REG_OPA,
        REG_OPB,
        REG_CMD,
        REG_STATUS,
        REG_RESULT,
        REG_FLAGS,
        // anything outside the map
        REG_NONE
    } apb_reg_e;

endpackage

// ==== source/alu_pkg.sv ====
`include "alu_consts.svh"

package alu_pkg;

    // operation select, also used as the adder carry-in
    typedef enum logic {
        ALU_ADD = 1'b0,
        ALU_SUB = 1'b1
    } alu_op_e;

    // one job as pushed by a CMD write, 65 bits
    typedef struct packed {
        logic [`ALU_DATA_W-1:0] operand_a;
        logic [`ALU_DATA_W-1:0] operand_b;
        alu_op_e                op;
    } alu_job_t;

    // one result, 34 bits
    typedef struct packed {
        logic [`ALU_DATA_W-1:0] sum;
        logic                   carry;
        logic                   overflow;
    } alu_result_t;

endpackage

// ==== include/alu_consts.svh ====
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// operand and result width
`define ALU_DATA_W      32
// entries in each of the job and result FIFOs
`define ALU_FIFO_DEPTH  4

// APB register map, byte offsets, one word each
`define ALU_REG_OPA     8'h00
`define ALU_REG_OPB     8'h04
`define ALU_REG_CMD     8'h08
`define ALU_REG_STATUS  8'h0C
`define ALU_REG_RESULT  8'h10
`define ALU_REG_FLAGS   8'h14

`endif
